//--- design/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // core bus widths
    localparam int addr_w = 64;
    localparam int data_w = 64;

    // bit 2 marks an unsigned load, bits 1:0 the size
    typedef logic [2:0] acc_type_t;

    localparam acc_type_t acc_lb  = 3'b000;
    localparam acc_type_t acc_lh  = 3'b001;
    localparam acc_type_t acc_lw  = 3'b010;
    localparam acc_type_t acc_ld  = 3'b011;
    localparam acc_type_t acc_lbu = 3'b100;
    localparam acc_type_t acc_lhu = 3'b101;
    localparam acc_type_t acc_lwu = 3'b110;

    localparam acc_type_t acc_sb  = 3'b000;
    localparam acc_type_t acc_sh  = 3'b001;
    localparam acc_type_t acc_sw  = 3'b010;
    localparam acc_type_t acc_sd  = 3'b011;

    // whole double word, or the two halves a double load fills in turn
    typedef union packed {
        logic [data_w-1:0] dword;
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } half;
    } bus_dword_u;

endpackage

`default_nettype wire

//--- design/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

    // data ram window, 4 KiB of 32-bit words
    localparam logic [63:0] ram_base  = 64'h0000_0000_0000_1000;
    localparam int          ram_words = 1024;

    // keyboard and console
    localparam logic [63:0] key_addr = 64'h0000_0000_0000_0100;
    localparam logic [63:0] art_addr = 64'h0000_0000_0000_0108;

    // sd card control registers
    localparam logic [63:0] sdc_addr_reg  = 64'h0000_0000_0000_0110;
    localparam logic [63:0] sdc_read_reg  = 64'h0000_0000_0000_0118;
    localparam logic [63:0] sdc_ready_reg = 64'h0000_0000_0000_0120;
    localparam logic [63:0] sdc_avail_reg = 64'h0000_0000_0000_0128;

    // sector buffer window, 512-byte aligned
    localparam logic [63:0] sdc_buf_base  = 64'h0000_0000_0000_2000;
    localparam int          sdc_buf_bytes = 512;

endpackage

`default_nettype wire

//--- design/key_irq_ctrl.sv
`default_nettype none

module key_irq_ctrl (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_pressed,
    input  logic [7:0] key_ascii,
    input  logic       interrupt_ack,
    output logic [3:0] interrupt_vector,
    output logic [7:0] key_code
);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= 4'd0;
            key_code         <= 8'd0;
        end else begin
            // code zero means no printable key, ignore it
            if (key_pressed && (key_ascii != 8'd0)) begin
                interrupt_vector <= 4'd1;
                key_code         <= key_ascii;
            end
            // ack comes last so it wins over a press in the same cycle
            if (interrupt_ack && (interrupt_vector != 4'd0)) begin
                interrupt_vector <= 4'd0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sd_sector_buffer.sv
`default_nettype none

module sd_sector_buffer
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic [7:0]        sd_dout,
    input  logic              sd_byte_available,
    input  logic [8:0]        buf_offset,
    output logic [data_w-1:0] buf_read_data,
    output logic              sector_available
);

    localparam int idx_w = $clog2(sdc_buf_bytes);

    logic [7:0]       sector_mem [sdc_buf_bytes];
    logic [idx_w-1:0] byte_index;
    logic             byte_avail_d;
    logic             byte_strobe;

    // one byte per rising edge of the controller's available level
    assign byte_strobe = sd_byte_available && !byte_avail_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            byte_avail_d     <= 1'b0;
            byte_index       <= '0;
            sector_available <= 1'b0;
        end else begin
            byte_avail_d <= sd_byte_available;
            if (byte_strobe) begin
                byte_index <= byte_index + 1'b1;
                if (byte_index == idx_w'(sdc_buf_bytes - 1)) begin
                    sector_available <= 1'b1;
                end else if (byte_index == '0) begin
                    // first byte of the next sector
                    sector_available <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_strobe) begin
            sector_mem[byte_index] <= sd_dout;
        end
    end

    // eight bytes little endian, offset wraps inside the sector
    always_comb begin
        for (int i = 0; i < data_w / 8; i++) begin
            buf_read_data[8*i +: 8] = sector_mem[buf_offset + idx_w'(i)];
        end
    end

endmodule

`default_nettype wire

//--- design/bus_ram.sv
`default_nettype none

module bus_ram
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              ram_read,
    input  logic              ram_write,
    input  logic [addr_w-1:0] ram_address,
    input  acc_type_t         ram_read_type,
    input  acc_type_t         ram_write_type,
    input  logic [data_w-1:0] ram_write_data,
    output bus_dword_u        ram_read_data,
    output logic              ram_read_valid
);

    localparam int idx_w = $clog2(ram_words);

    logic [31:0]       mem [ram_words];
    logic [addr_w-1:0] ram_offs;
    logic [idx_w-1:0]  base_idx;
    logic [idx_w-1:0]  rd_idx;
    logic [idx_w-1:0]  wr_idx;
    logic [1:0]        byte_off;
    logic              rd_beat2;
    logic              wr_beat2;
    logic [3:0]        wr_be;
    logic [31:0]       wr_word;
    logic [31:0]       rd_word;

    assign ram_offs = ram_address - ram_base;
    assign base_idx = ram_offs[idx_w+1:2];
    assign byte_off = ram_offs[1:0];

    // second beat of a double goes to the next word
    assign rd_idx  = rd_beat2 ? base_idx + 1'b1 : base_idx;
    assign wr_idx  = wr_beat2 ? base_idx + 1'b1 : base_idx;
    assign rd_word = mem[rd_idx];

    // byte lanes and lane data per store size
    always_comb begin
        wr_be   = 4'b1111;
        wr_word = ram_write_data[31:0];
        if (wr_beat2) begin
            wr_word = ram_write_data[63:32];
        end else begin
            case (ram_write_type)
                acc_sb: begin
                    wr_be   = 4'b0001 << byte_off;
                    wr_word = {4{ram_write_data[7:0]}};
                end
                acc_sh: begin
                    wr_be   = 4'b0011 << byte_off;
                    wr_word = {2{ram_write_data[15:0]}};
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_write || wr_beat2) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i])
                    mem[wr_idx][8*i +: 8] <= wr_word[8*i +: 8];
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd_beat2) begin
            ram_read_data.half.hi <= rd_word;
        end else if (ram_read) begin
            if (ram_read_type[1:0] == acc_ld[1:0])
                ram_read_data.half.lo <= rd_word;
            else
                ram_read_data.dword <= {32'd0, rd_word >> {byte_off, 3'b000}};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_beat2       <= 1'b0;
            wr_beat2       <= 1'b0;
            ram_read_valid <= 1'b0;
        end else begin
            rd_beat2       <= ram_read && (ram_read_type[1:0] == acc_ld[1:0]);
            wr_beat2       <= ram_write && (ram_write_type == acc_sd);
            ram_read_valid <= ram_read || rd_beat2;
        end
    end

endmodule

`default_nettype wire

//--- design/mmio_fabric.sv
`default_nettype none

module mmio_fabric
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic [addr_w-1:0] bus_address,
    input  logic              bus_read_enable,
    input  acc_type_t         bus_read_type,
    input  logic              bus_write_enable,
    input  acc_type_t         bus_write_type,
    input  logic [data_w-1:0] bus_write_data,
    output logic [data_w-1:0] bus_read_data,
    output logic              bus_read_done,
    output logic              ram_read,
    output logic              ram_write,
    input  bus_dword_u        ram_read_data,
    input  logic              ram_read_valid,
    input  logic [7:0]        key_code,
    input  logic [data_w-1:0] buf_read_data,
    input  logic              sector_available,
    input  logic              sd_ready,
    output logic [31:0]       sd_addr,
    output logic              sd_rd_start,
    output logic              uart_write_pulse,
    output logic [31:0]       uart_write_data
);

    logic              sel_ram;
    logic              sel_buf;
    logic [data_w-1:0] dev_rdata;
    logic [31:0]       store_word;
    logic              dev_pend;
    logic              dbl_first;
    logic              is_dbl;
    logic              ram_last;
    logic              wr_en_d;
    logic              wr_rise;

    assign sel_ram = (bus_address >= ram_base) &&
                     (bus_address < ram_base + 64'(ram_words * 4));
    assign sel_buf = (bus_address >= sdc_buf_base) &&
                     (bus_address < sdc_buf_base + 64'(sdc_buf_bytes));

    // device registers, zero extended, anything unmapped reads zero
    always_comb begin
        dev_rdata = '0;
        if (sel_buf)
            dev_rdata = buf_read_data;
        else if (bus_address == key_addr)
            dev_rdata = {56'd0, key_code};
        else if (bus_address == sdc_addr_reg)
            dev_rdata = {32'd0, sd_addr};
        else if (bus_address == sdc_ready_reg)
            dev_rdata = {63'd0, sd_ready};
        else if (bus_address == sdc_avail_reg)
            dev_rdata = {63'd0, sector_available};
    end

    // a double completes on the second valid from the ram
    assign is_dbl   = (bus_read_type[1:0] == acc_ld[1:0]);
    assign ram_last = ram_read_valid && (!is_dbl || dbl_first);
    assign ram_read = bus_read_enable && sel_ram;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
            dev_pend      <= 1'b0;
            dbl_first     <= 1'b0;
        end else begin
            if (bus_read_enable) begin
                bus_read_done <= 1'b0;
                dev_pend      <= !sel_ram;
            end
            if (dev_pend) begin
                bus_read_done <= 1'b1;
                dev_pend      <= 1'b0;
            end
            if (ram_read_valid) begin
                dbl_first <= is_dbl && !dbl_first;
            end
            if (ram_last) begin
                bus_read_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (dev_pend)
            bus_read_data <= dev_rdata;
        else if (ram_last)
            bus_read_data <= ram_read_data.dword;
    end

    // only the first cycle of a write strobe counts
    assign wr_rise   = bus_write_enable && !wr_en_d;
    assign ram_write = wr_rise && sel_ram;

    // narrow stores to the sector address load zero extended
    always_comb begin
        case (bus_write_type)
            acc_sb:  store_word = {24'd0, bus_write_data[7:0]};
            acc_sh:  store_word = {16'd0, bus_write_data[15:0]};
            default: store_word = bus_write_data[31:0];
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_en_d     <= 1'b0;
            sd_addr     <= 32'd0;
            sd_rd_start <= 1'b0;
        end else begin
            wr_en_d     <= bus_write_enable;
            sd_rd_start <= wr_rise && (bus_address == sdc_read_reg);
            if (wr_rise && (bus_address == sdc_addr_reg)) begin
                sd_addr <= store_word;
            end
        end
    end

    // console strobe toward the uart
    assign uart_write_pulse = wr_rise && (bus_address == art_addr);
    assign uart_write_data  = bus_write_data[31:0];

endmodule

`default_nettype wire

//--- design/soc_bus_top.sv
`default_nettype none

module soc_bus_top
    import soc_bus_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic [addr_w-1:0] bus_address,
    input  logic              bus_read_enable,
    input  acc_type_t         bus_read_type,
    input  logic              bus_write_enable,
    input  acc_type_t         bus_write_type,
    input  logic [data_w-1:0] bus_write_data,
    output logic [data_w-1:0] bus_read_data,
    output logic              bus_read_done,
    input  logic              key_pressed,
    input  logic [7:0]        key_ascii,
    input  logic              interrupt_ack,
    output logic [3:0]        interrupt_vector,
    input  logic [7:0]        sd_dout,
    input  logic              sd_byte_available,
    input  logic              sd_ready,
    output logic [31:0]       sd_addr,
    output logic              sd_rd_start,
    output logic              uart_write_pulse,
    output logic [31:0]       uart_write_data
);

    logic              ram_read;
    logic              ram_write;
    bus_dword_u        ram_read_data;
    logic              ram_read_valid;
    logic [7:0]        key_code;
    logic [data_w-1:0] buf_read_data;
    logic              sector_available;

    // keyboard interrupt
    key_irq_ctrl key_irq_ctrl_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_pressed      (key_pressed),
        .key_ascii        (key_ascii),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector),
        .key_code         (key_code)
    );

    // sector bytes from the card controller
    sd_sector_buffer sd_sector_buffer_i (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .buf_offset        (bus_address[8:0]),
        .buf_read_data     (buf_read_data),
        .sector_available  (sector_available)
    );

    bus_ram bus_ram_i (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .ram_read       (ram_read),
        .ram_write      (ram_write),
        .ram_address    (bus_address),
        .ram_read_type  (bus_read_type),
        .ram_write_type (bus_write_type),
        .ram_write_data (bus_write_data),
        .ram_read_data  (ram_read_data),
        .ram_read_valid (ram_read_valid)
    );

    mmio_fabric mmio_fabric_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_read_enable  (bus_read_enable),
        .bus_read_type    (bus_read_type),
        .bus_write_enable (bus_write_enable),
        .bus_write_type   (bus_write_type),
        .bus_write_data   (bus_write_data),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .ram_read         (ram_read),
        .ram_write        (ram_write),
        .ram_read_data    (ram_read_data),
        .ram_read_valid   (ram_read_valid),
        .key_code         (key_code),
        .buf_read_data    (buf_read_data),
        .sector_available (sector_available),
        .sd_ready         (sd_ready),
        .sd_addr          (sd_addr),
        .sd_rd_start      (sd_rd_start),
        .uart_write_pulse (uart_write_pulse),
        .uart_write_data  (uart_write_data)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic CLOCK_50,
    output logic KEY0
);

    // period of 4 time units
    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // reset held low for four cycles
    initial begin
        KEY0 = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/soc_bus_tb.sv
`default_nettype none

module soc_bus_tb
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
();

    // about twice the cycles taken by all tests together
    localparam int cycle_limit = 6000;

    logic              CLOCK_50;
    logic              KEY0;
    logic [addr_w-1:0] bus_address;
    logic              bus_read_enable;
    acc_type_t         bus_read_type;
    logic              bus_write_enable;
    acc_type_t         bus_write_type;
    logic [data_w-1:0] bus_write_data;
    logic [data_w-1:0] bus_read_data;
    logic              bus_read_done;
    logic              key_pressed;
    logic [7:0]        key_ascii;
    logic              interrupt_ack;
    logic [3:0]        interrupt_vector;
    logic [7:0]        sd_dout;
    logic              sd_byte_available;
    logic              sd_ready;
    logic [31:0]       sd_addr;
    logic              sd_rd_start;
    logic              uart_write_pulse;
    logic [31:0]       uart_write_data;

    logic [15:0] lfsr_state = 16'd47770;
    logic [7:0]  model_mem [ram_words * 4];
    logic [7:0]  sector_model [sdc_buf_bytes];
    bus_dword_u  exp_q [$];
    string       name_q [$];
    logic        done_prev = 1'b1;
    int          cycles = 0;
    int          start_count = 0;
    int          uart_count = 0;
    logic [31:0] uart_seen;
    acc_type_t   load_types [7] = '{acc_lb, acc_lh, acc_lw, acc_ld, acc_lbu, acc_lhu, acc_lwu};

    tb_clock_gen tb_clock_gen_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    soc_bus_top soc_bus_top_i (.*);

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic compare_dword(input string name, input bus_dword_u exp, input bus_dword_u act);
        if (act !== exp)
            stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_with_failure($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // narrow loads shift the word down and zero fill while a double joins two words
    function automatic bus_dword_u expected_load(input int off, input acc_type_t t);
        bus_dword_u r;
        int         idx;
        logic [31:0] w0;
        logic [31:0] w1;
        idx = off / 4;
        for (int k = 0; k < 4; k++) begin
            w0[8*k +: 8] = model_mem[4 * idx + k];
            w1[8*k +: 8] = model_mem[4 * ((idx + 1) % ram_words) + k];
        end
        if (t[1:0] == 2'd3) begin
            r.half.lo = w0;
            r.half.hi = w1;
        end else begin
            r.dword = {32'd0, w0 >> (8 * (off % 4))};
        end
        return r;
    endfunction

    function automatic bus_dword_u expected_sector(input int off);
        bus_dword_u r;
        for (int i = 0; i < 8; i++)
            r.dword[8*i +: 8] = sector_model[(off + i) % sdc_buf_bytes];
        return r;
    endfunction

    function automatic void model_store(input int off, input logic [1:0] size,
                                        input logic [63:0] d);
        for (int k = 0; k < (1 << size); k++)
            model_mem[off + k] = d[8*k +: 8];
    endfunction

    task automatic bus_store(input logic [63:0] addr, input acc_type_t t, input logic [63:0] d);
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_write_type   <= t;
        bus_write_data   <= d;
        bus_write_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
        @(posedge CLOCK_50);
    endtask

    task automatic bus_load(input logic [63:0] addr, input acc_type_t t,
                            input bus_dword_u exp, input string name);
        @(posedge CLOCK_50);
        exp_q.push_back(exp);
        name_q.push_back(name);
        bus_address     <= addr;
        bus_read_type   <= t;
        bus_read_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
        do @(negedge CLOCK_50); while (!bus_read_done);
    endtask

    task automatic stream_byte(input logic [7:0] b);
        @(posedge CLOCK_50);
        sd_dout           <= b;
        sd_byte_available <= 1'b1;
        @(posedge CLOCK_50);
        sd_byte_available <= 1'b0;
    endtask

    task automatic press_key(input logic [7:0] code);
        @(posedge CLOCK_50);
        key_pressed <= 1'b1;
        key_ascii   <= code;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    // every completed read is checked against the oldest expectation
    always @(negedge CLOCK_50) begin
        if (KEY0 && bus_read_done && !done_prev) begin
            if (exp_q.size() == 0)
                stop_with_failure("a read completed with no expected value waiting");
            else
                compare_dword(name_q.pop_front(), exp_q.pop_front(), bus_read_data);
        end
        done_prev = bus_read_done;
    end

    // strobe monitors
    always @(negedge CLOCK_50) begin
        if (sd_rd_start === 1'b1)
            start_count++;
        if (uart_write_pulse === 1'b1) begin
            uart_count++;
            uart_seen = uart_write_data;
        end
    end

    always @(posedge CLOCK_50) begin
        cycles++;
        if (cycles > cycle_limit)
            stop_with_failure("timeout, the tests did not finish within the cycle limit");
    end

    initial begin
        logic [63:0] d;
        logic [1:0]  size;
        logic [7:0]  code;
        int          off;
        int          sd_idx;
        bus_address       = '0;
        bus_read_enable   = 1'b0;
        bus_read_type     = acc_lw;
        bus_write_enable  = 1'b0;
        bus_write_type    = acc_sw;
        bus_write_data    = '0;
        key_pressed       = 1'b0;
        key_ascii         = 8'd0;
        interrupt_ack     = 1'b0;
        sd_dout           = 8'd0;
        sd_byte_available = 1'b0;
        sd_ready          = 1'b0;
        sd_idx            = 0;
        wait (KEY0 === 1'b1);
        @(negedge CLOCK_50);

        // reset state
        compare_bit("reset done", 1'b1, bus_read_done);
        compare_byte("reset vector", 8'd0, {4'd0, interrupt_vector});
        compare_bit("reset sd start", 1'b0, sd_rd_start);
        compare_bit("reset uart pulse", 1'b0, uart_write_pulse);
        bus_load(sdc_avail_reg, acc_ld, 64'd0, "reset avail");
        bus_load(64'h800, acc_ld, 64'd0, "unmapped read");

        // known contents in the low 520 bytes where the random accesses go
        for (int i = 0; i < 65; i++) begin
            d = random_bits(64);
            bus_store(ram_base + 64'(8 * i), acc_sd, d);
            model_store(8 * i, 2'd3, d);
        end
        for (int n = 0; n < 60; n++) begin
            size = random_bits(2);
            off  = int'(random_bits(9)) & ~((1 << size) - 1);
            d    = random_bits(64);
            bus_store(ram_base + 64'(off), acc_type_t'(size), d);
            model_store(off, size, d);
            for (int t = 0; t < 7; t++)
                bus_load(ram_base + 64'(off), load_types[t], expected_load(off, load_types[t]),
                         $sformatf("ram store %0d load type %0d", n, load_types[t]));
        end

        // keyboard
        code = 8'h20 + random_bits(6);
        press_key(code);
        compare_byte("key vector set", 8'd1, {4'd0, interrupt_vector});
        bus_load(key_addr, acc_lbu, {56'd0, code}, "key code");
        @(posedge CLOCK_50);
        interrupt_ack <= 1'b1;
        @(posedge CLOCK_50);
        interrupt_ack <= 1'b0;
        @(negedge CLOCK_50);
        compare_byte("key vector ack", 8'd0, {4'd0, interrupt_vector});
        press_key(8'd0);
        compare_byte("key zero code", 8'd0, {4'd0, interrupt_vector});
        bus_load(key_addr, acc_lbu, {56'd0, code}, "key code kept");

        // sd card registers and sector buffer
        d = random_bits(32);
        bus_store(sdc_addr_reg, acc_sw, d);
        @(negedge CLOCK_50);
        compare_dword("sd addr out", {32'd0, d[31:0]}, {32'd0, sd_addr});
        bus_load(sdc_addr_reg, acc_lwu, {32'd0, d[31:0]}, "sd addr read");
        bus_store(sdc_read_reg, acc_sw, 64'd1);
        repeat (2) @(negedge CLOCK_50);
        compare_byte("sd start pulses", 8'd1, 8'(start_count));
        for (int i = 0; i < sdc_buf_bytes; i++) begin
            d = random_bits(8);
            sector_model[sd_idx] = d[7:0];
            sd_idx = (sd_idx + 1) % sdc_buf_bytes;
            stream_byte(d[7:0]);
        end
        bus_load(sdc_avail_reg, acc_ld, 64'd1, "sector full");
        @(posedge CLOCK_50);
        sd_ready <= 1'b1;
        bus_load(sdc_ready_reg, acc_ld, 64'd1, "sd ready high");
        @(posedge CLOCK_50);
        sd_ready <= 1'b0;
        bus_load(sdc_ready_reg, acc_ld, 64'd0, "sd ready low");
        for (int i = 0; i < 8; i++) begin
            off = int'(random_bits(9));
            bus_load(sdc_buf_base + 64'(off), acc_ld, expected_sector(off),
                     $sformatf("sector offset %0d", off));
        end
        stream_byte(random_bits(8));
        bus_load(sdc_avail_reg, acc_ld, 64'd0, "sector flag cleared");

        // console strobe with the enable held for three cycles
        d = random_bits(64);
        @(posedge CLOCK_50);
        bus_address      <= art_addr;
        bus_write_type   <= acc_sw;
        bus_write_data   <= d;
        bus_write_enable <= 1'b1;
        repeat (3) @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
        repeat (2) @(negedge CLOCK_50);
        compare_byte("uart pulses", 8'd1, 8'(uart_count));
        compare_dword("uart data", {32'd0, d[31:0]}, {32'd0, uart_seen});

        @(negedge CLOCK_50);
        if (exp_q.size() != 0) begin
            stop_with_failure("some reads never completed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
design/soc_bus_pkg.sv
design/soc_map_pkg.sv
design/key_irq_ctrl.sv
design/sd_sector_buffer.sv
design/bus_ram.sv
design/mmio_fabric.sv
design/soc_bus_top.sv
verification/tb_clock_gen.sv
verification/soc_bus_tb.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - design/soc_bus_pkg.sv
  - design/soc_map_pkg.sv
  - design/key_irq_ctrl.sv
  - design/sd_sector_buffer.sv
  - design/bus_ram.sv
  - design/mmio_fabric.sv
  - design/soc_bus_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/soc_bus_tb.sv
